// File: hw/uart_settings.svh
// Timing constants for the UART. UART_CLK_HZ must be a whole multiple of
// UART_BAUD * UART_OVERSAMPLE, or the baud rate comes out slightly off
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// ==========================================================================
// Base rates
// ==========================================================================
`define UART_CLK_HZ     1843200      // System clock, simulation value
`define UART_BAUD       115200       // Line rate in bits per second
`define UART_OVERSAMPLE 16           // Ticks per bit on both tx and rx

// ==========================================================================
// Derived values
// ==========================================================================
// Clocks per oversample tick, 1 with the simulation clock
`define UART_TICK_DIV   (`UART_CLK_HZ / (`UART_BAUD * `UART_OVERSAMPLE))

// Width of the per-bit tick counter
`define UART_OS_W       ($clog2(`UART_OVERSAMPLE))

// Width of the baud divider counter, always at least one bit
`define UART_DIV_W      ($clog2(`UART_TICK_DIV) + 1)

`endif

// File: hw/uart_pkg.sv
// Shared types for the UART blocks. The timing constants are kept in
// uart_settings.svh
`default_nettype none

package uart_pkg;

   // =======================================================================
   // Transmitter states
   // =======================================================================
   // One state per field of the frame, DATA covers all eight data bits
   typedef enum logic [2:0] {
      TX_IDLE  = 3'd0,   // Line high, waiting for a write
      TX_START = 3'd1,   // Start bit, line low
      TX_DATA  = 3'd2,   // D0..D7, LSB first
      TX_STOP  = 3'd3,   // Stop bit, line high
      TX_GAP   = 3'd4    // Extra high bit between characters
   } tx_state_e;

   // =======================================================================
   // Receiver states
   // =======================================================================
   typedef enum logic [1:0] {
      RX_IDLE  = 2'd0,   // Hunting for a falling edge
      RX_START = 2'd1,   // Waiting for the middle of the start bit
      RX_DATA  = 2'd2,   // Sampling eight data bits
      RX_STOP  = 2'd3    // Sampling the stop bit
   } rx_state_e;

   // =======================================================================
   // Received character
   // =======================================================================
   // Held by the receiver until the next rx_valid pulse
   typedef struct packed {
      logic [7:0] data;          // Byte as received, D0 in bit 0
      logic       frame_error;   // Stop bit sampled low
   } rx_frame_t;

endpackage

`default_nettype wire

// File: hw/uart_baud_gen.sv
// Free-running oversample tick, one clock wide every UART_TICK_DIV clocks
// With a divisor of 1 the tick is high in every cycle
`timescale 1ns/1ns
`default_nettype none

`include "uart_settings.svh"

module uart_baud_gen (
   input  logic clk,
   input  logic reset,
   output logic tick      // One-cycle oversample strobe
);

   // =======================================================================
   // Divider constants
   // =======================================================================
   localparam int DIV_W = `UART_DIV_W;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_TICK_DIV - 1);

   logic [DIV_W-1:0] div_cnt;   // Clocks since the last tick

   // Tick on the last count of the period, the counter wraps in the same cycle
   assign tick = (div_cnt == DIV_LAST);

   // =======================================================================
   // Divider counter
   // =======================================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         div_cnt <= '0;
      end
      else if (tick) begin
         div_cnt <= '0;                    // Wrap, next period starts
      end
      else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// 8N1 transmitter that adds one high gap bit after every stop bit
// A write while tx_busy is high is dropped. There is no back-pressure
`timescale 1ns/1ns
`default_nettype none

`include "uart_settings.svh"

module uart_tx (
   input  logic       clk,
   input  logic       reset,
   input  logic       tick,      // Oversample strobe from the baud generator
   input  logic [7:0] tx_data,   // Byte to send, taken on an accepted write
   input  logic       tx_wr,     // Write strobe from the host
   output logic       txd,       // Serial line, idles high
   output logic       tx_busy    // High while a frame is on the line
);
   import uart_pkg::*;

   // =======================================================================
   // Constants and state
   // =======================================================================
   localparam int OS_W = `UART_OS_W;
   localparam logic [OS_W-1:0] TICK_LAST = OS_W'(`UART_OVERSAMPLE - 1);

   tx_state_e        state;
   logic [OS_W-1:0]  tick_cnt;    // Ticks spent in the current bit
   logic [2:0]       bit_idx;     // Data bit being sent
   logic [7:0]       shreg;       // Remaining data bits, next one in bit 0
   logic             wr_ok;       // Write taken this cycle
   logic             bit_end;     // Last tick of the current bit

   assign wr_ok   = tx_wr && (state == TX_IDLE);
   assign bit_end = tick && (tick_cnt == TICK_LAST);
   assign tx_busy = (state != TX_IDLE);   // Includes the gap bit

   // =======================================================================
   // Frame sequencer
   // =======================================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= TX_IDLE;
         tick_cnt <= '0;
         bit_idx  <= '0;
         txd      <= 1'b1;                 // Line idles high
      end
      else begin
         // Bit timer, overridden below on a write
         if (bit_end) begin
            tick_cnt <= '0;
         end
         else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
         end

         case (state)
            TX_IDLE: begin
               if (wr_ok) begin
                  state    <= TX_START;
                  tick_cnt <= '0;          // First bit starts right away
                  txd      <= 1'b0;        // Start bit
               end
            end
            TX_START: begin
               if (bit_end) begin
                  state   <= TX_DATA;
                  bit_idx <= '0;
                  txd     <= shreg[0];     // D0
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     state <= TX_STOP;
                     txd   <= 1'b1;        // Stop bit
                  end
                  else begin
                     bit_idx <= bit_idx + 1'b1;
                     txd     <= shreg[0];  // Next data bit
                  end
               end
            end
            TX_STOP: begin
               if (bit_end) state <= TX_GAP;   // Line stays high
            end
            TX_GAP: begin
               if (bit_end) state <= TX_IDLE;
            end
            default: begin
               state <= TX_IDLE;
               txd   <= 1'b1;
            end
         endcase
      end
   end

   // Payload shift register, loaded on a write and shifted as each bit leaves
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         shreg <= tx_data;
      end
      else if (bit_end && (state == TX_START || state == TX_DATA)) begin
         shreg <= shreg >> 1;
      end
   end

endmodule

`default_nettype wire

// File: hw/uart_rx.sv
// 16x oversampling 8N1 receiver. A low pulse shorter than half a bit is
// rejected, and a low stop bit still delivers the byte with frame_error set
`timescale 1ns/1ns
`default_nettype none

`include "uart_settings.svh"

module uart_rx (
   input  logic                clk,
   input  logic                reset,
   input  logic                tick,       // Oversample strobe
   input  logic                rxd,        // Asynchronous serial input
   output uart_pkg::rx_frame_t rx_frame,   // Last received character
   output logic                rx_valid    // One-cycle strobe per character
);
   import uart_pkg::*;

   // =======================================================================
   // Constants and state
   // =======================================================================
   localparam int OS_W = `UART_OS_W;
   localparam logic [OS_W-1:0] TICK_LAST = OS_W'(`UART_OVERSAMPLE - 1);
   localparam logic [OS_W-1:0] HALF_LAST = OS_W'(`UART_OVERSAMPLE / 2 - 1);

   rx_state_e        state;
   logic [OS_W-1:0]  tick_cnt;     // Ticks since the last sample point
   logic [2:0]       bit_idx;      // Data bit being sampled
   logic [7:0]       shreg;        // Assembled byte, filled from the top
   logic             rxd_meta;     // First synchronizer stage
   logic             rxd_s;        // Synchronized line
   logic             rxd_d;        // One cycle older, for edge detect
   logic             fall;         // High to low transition seen
   logic             half_end;     // Middle of the start bit
   logic             bit_end;      // Middle of a data or stop bit

   assign fall     = rxd_d && !rxd_s;
   assign half_end = tick && (tick_cnt == HALF_LAST);
   assign bit_end  = tick && (tick_cnt == TICK_LAST);

   // =======================================================================
   // Input synchronizer
   // =======================================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rxd_meta <= 1'b1;          // Idle line level
         rxd_s    <= 1'b1;
         rxd_d    <= 1'b1;
      end
      else begin
         rxd_meta <= rxd;
         rxd_s    <= rxd_meta;
         rxd_d    <= rxd_s;
      end
   end

   // =======================================================================
   // Receive FSM
   // =======================================================================
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= RX_IDLE;
         tick_cnt <= '0;
         bit_idx  <= '0;
         rx_frame <= '0;
         rx_valid <= 1'b0;
      end
      else begin
         rx_valid <= 1'b0;                 // Strobe by default
         if (tick) tick_cnt <= tick_cnt + 1'b1;

         case (state)
            RX_IDLE: begin
               tick_cnt <= '0;             // Hold the timer while hunting
               if (fall) state <= RX_START;
            end
            RX_START: begin
               // Mid-bit check of the start bit, a glitch has gone high again
               if (half_end) begin
                  tick_cnt <= '0;
                  bit_idx  <= '0;
                  state    <= rxd_s ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  tick_cnt <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  tick_cnt             <= '0;
                  rx_frame.data        <= shreg;
                  rx_frame.frame_error <= !rxd_s;   // Stop must be high
                  rx_valid             <= 1'b1;
                  state                <= RX_IDLE;  // Resume hunting mid-stop
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Data bits arrive LSB first, so shift in from the top
   always_ff @(posedge clk) begin
      if (state == RX_DATA && bit_end) begin
         shreg <= {rxd_s, shreg[7:1]};
      end
   end

endmodule

`default_nettype wire

// File: hw/uart_top.sv
// Serial port with one shared baud tick for transmit and receive
// Host side uses plain strobes only, no FIFO and no flow control
`timescale 1ns/1ns
`default_nettype none

module uart_top (
   input  logic                clk,
   input  logic                reset,
   input  logic [7:0]          tx_data,    // Byte to transmit
   input  logic                tx_wr,      // Write strobe, ignored while busy
   input  logic                rxd,        // Serial input line
   output logic                txd,        // Serial output line
   output logic                tx_busy,    // Transmitter has a frame in flight
   output uart_pkg::rx_frame_t rx_frame,   // Received byte and stop status
   output logic                rx_valid    // One cycle per received frame
);

   // =======================================================================
   // Shared oversample tick
   // =======================================================================
   logic tick;

   uart_baud_gen u_baud_gen (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   // =======================================================================
   // Transmit path
   // =======================================================================
   uart_tx u_tx (
      .clk     (clk),
      .reset   (reset),
      .tick    (tick),
      .tx_data (tx_data),
      .tx_wr   (tx_wr),
      .txd     (txd),
      .tx_busy (tx_busy)
   );

   // =======================================================================
   // Receive path
   // =======================================================================
   uart_rx u_rx (
      .clk      (clk),
      .reset    (reset),
      .tick     (tick),
      .rxd      (rxd),
      .rx_frame (rx_frame),
      .rx_valid (rx_valid)
   );

endmodule

`default_nettype wire

// File: verification/uart_sva.sv
// Protocol properties of uart_top, bound into the top level
// Nothing is checked while reset is high
`timescale 1ns/1ns
`default_nettype none

module uart_sva (
   input logic clk,
   input logic reset,
   input logic tx_wr,
   input logic tx_busy,
   input logic txd,
   input logic rx_valid
);

   // Idle transmitter keeps the line high
   property idle_line_high;
      @(posedge clk) disable iff (reset) !tx_busy |-> txd;
   endproperty

   property valid_single_cycle;
      @(posedge clk) disable iff (reset) rx_valid |=> !rx_valid;
   endproperty

   // Write taken in IDLE, busy on the next clock
   property busy_after_write;
      @(posedge clk) disable iff (reset) (tx_wr && !tx_busy) |=> tx_busy;
   endproperty

   a_idle_line_high: assert property (idle_line_high)
      else $error("txd low while the transmitter is idle");
   a_valid_single_cycle: assert property (valid_single_cycle)
      else $error("rx_valid high in two consecutive cycles");
   a_busy_after_write: assert property (busy_after_write)
      else $error("tx_busy did not rise after an accepted write");

endmodule

`default_nettype wire

// File: verification/uart_checker.sv
// Scoreboard for uart_top. The tx model counts bit times from the cycle after
// an accepted write, so it needs a tick divisor that gives whole-clock bits
`timescale 1ns/1ns
`default_nettype none

`include "uart_settings.svh"

module uart_checker (
   input logic                clk,
   input logic                reset,
   input logic [7:0]          tx_data,
   input logic                tx_wr,
   input logic                txd,
   input logic                tx_busy,
   input logic                loopback,    // rx gets what tx sends
   input uart_pkg::rx_frame_t rx_frame,
   input logic                rx_valid
);
   import uart_pkg::*;

   localparam int BIT_CLKS   = `UART_OVERSAMPLE * `UART_TICK_DIV;
   localparam int FRAME_CLKS = 11 * BIT_CLKS;

   int         errors       = 0;
   int         tests_run    = 0;
   int         tests_failed = 0;
   int         test_errors  = 0;
   string      test_name    = "none";
   rx_frame_t  rx_expect[$];    // Frames still owed by the receiver
   rx_frame_t  rx_head;
   logic       tx_active;       // Model is inside a frame
   int         tx_n;            // Clocks since the accepted write
   logic [7:0] tx_byte;         // Byte latched at the accepted write
   logic       exp_bit;

   // Line level of bit k in the 11-bit frame
   function automatic logic frame_bit(input logic [7:0] d, input int k);
      logic [7:0] s;
      if (k == 0) return 1'b0;
      if (k > 8) return 1'b1;                   // Stop and gap
      s = d >> (k - 1);
      return s[0];
   endfunction

   task automatic wrong_value(input string what, input int expected, input int actual);
      $display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
      errors++;
      test_errors++;
   endtask

   task automatic note_failure(input string msg);
      $display("%s: %s", test_name, msg);
      errors++;
      test_errors++;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = 0;
   endtask

   task automatic expect_rx(input rx_frame_t f);
      rx_expect.push_back(f);
   endtask

   task automatic close_test();
      if (rx_expect.size() != 0) begin
         note_failure($sformatf("%0d expected rx frames never arrived", rx_expect.size()));
         rx_expect.delete();
      end
      tests_run++;
      if (test_errors == 0) begin
         $display("TEST %s: passed", test_name);
      end
      else begin
         tests_failed++;
         $display("TEST %s: failed with %0d errors", test_name, test_errors);
      end
   endtask

   // ========================================================================
   // Transmit model and receive scoreboard
   // ========================================================================
   always @(posedge clk) begin
      if (reset) begin
         tx_active = 1'b0;
         tx_n      = 0;
      end
      else begin
         if (tx_active) begin
            tx_n++;
            exp_bit = frame_bit(tx_byte, tx_n / BIT_CLKS);
            if (tx_n % BIT_CLKS == BIT_CLKS / 2 && txd !== exp_bit)  // Mid-bit
               wrong_value($sformatf("txd bit %0d", tx_n / BIT_CLKS), int'(exp_bit), int'(txd));
            if (tx_n <= FRAME_CLKS && tx_busy !== 1'b1)
               wrong_value("tx_busy in frame", 1, int'(tx_busy));
            if (tx_n == FRAME_CLKS + 1) begin
               if (tx_busy !== 1'b0) wrong_value("tx_busy after frame", 0, int'(tx_busy));
               tx_active = 1'b0;
            end
         end
         else if (txd !== 1'b1 || tx_busy !== 1'b0) begin
            note_failure("transmitter not idle outside a frame");
         end

         if (!tx_active && tx_wr) begin  // Accepted write
            tx_active = 1'b1;
            tx_n      = 0;
            tx_byte   = tx_data;
            if (loopback) rx_expect.push_back({tx_data, 1'b0});
         end

         if (rx_valid) begin
            if (rx_expect.size() == 0) begin
               note_failure("rx_valid pulsed with no frame outstanding");
            end
            else begin
               rx_head = rx_expect.pop_front();
               if (rx_frame.data !== rx_head.data)
                  wrong_value("rx data", int'(rx_head.data), int'(rx_frame.data));
               if (rx_frame.frame_error !== rx_head.frame_error)
                  wrong_value("frame_error", int'(rx_head.frame_error),
                              int'(rx_frame.frame_error));
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verification/uart_tb.sv
// Testbench for uart_top with random bytes from a fixed xorshift seed
// Bit timing assumes the whole-clock tick divisor from uart_settings.svh
`timescale 1ns/1ns
`default_nettype none

`include "uart_settings.svh"

module uart_tb;
   import uart_pkg::*;

   // ========================================================================
   // Test sizes and run limit
   // ========================================================================
   localparam int BIT_CLKS   = `UART_OVERSAMPLE * `UART_TICK_DIV;
   localparam int FRAME_CLKS = 11 * BIT_CLKS;      // Start, 8 data, stop, gap
   localparam int RESET_CLKS = 16;
   localparam int IDLE_CLKS  = 24;                 // High time after a driven frame
   localparam int N_TX       = 64;
   localparam int N_IGNORE   = 16;
   localparam int N_B2B      = 32;
   localparam int N_FERR     = 16;
   localparam int N_GLITCH   = 8;
   localparam int N_FRAMES   = N_TX + N_IGNORE + N_B2B + N_FERR + N_GLITCH;
   localparam int WATCHDOG_CLKS = N_FRAMES * 200 + RESET_CLKS;

   logic       clk;
   logic       reset;
   logic [7:0] tx_data;
   logic       tx_wr;
   logic       txd;
   logic       tx_busy;
   logic       rxd;
   logic       rxd_drv;        // Bit-level frames built by the testbench
   logic       loopback;       // 1 routes txd back into rxd
   logic       stop_bit;
   rx_frame_t  rx_frame;
   logic       rx_valid;
   logic [31:0] rng;

   assign rxd = loopback ? txd : rxd_drv;

   uart_top UUT (
      .clk      (clk),
      .reset    (reset),
      .tx_data  (tx_data),
      .tx_wr    (tx_wr),
      .rxd      (rxd),
      .txd      (txd),
      .tx_busy  (tx_busy),
      .rx_frame (rx_frame),
      .rx_valid (rx_valid)
   );

   uart_checker u_checker (
      .clk      (clk),
      .reset    (reset),
      .tx_data  (tx_data),
      .tx_wr    (tx_wr),
      .txd      (txd),
      .tx_busy  (tx_busy),
      .loopback (loopback),
      .rx_frame (rx_frame),
      .rx_valid (rx_valid)
   );

   bind uart_top uart_sva u_sva (
      .clk      (clk),
      .reset    (reset),
      .tx_wr    (tx_wr),
      .tx_busy  (tx_busy),
      .txd      (txd),
      .rx_valid (rx_valid)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // One-cycle write strobe that the DUT takes on the next edge
   task automatic write_byte(input logic [7:0] b);
      tx_data <= b;
      tx_wr   <= 1'b1;
      @(posedge clk);
      tx_wr   <= 1'b0;
   endtask

   // Returns on the first edge that sees tx_busy low
   task automatic wait_idle();
      @(posedge clk);
      while (tx_busy) @(posedge clk);
   endtask

   task automatic drive_line(input logic level, input int clks);
      rxd_drv <= level;
      repeat (clks) @(posedge clk);
   endtask

   task automatic send_frame(input logic [7:0] b, input logic stop);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};                     // Start bit goes out first
      for (int i = 0; i < 10; i++) begin
         drive_line(bits[0], BIT_CLKS);
         bits = bits >> 1;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CLKS) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d clocks", WATCHDOG_CLKS);
      $display("** FAIL **");
      $finish;
   end

   // ========================================================================
   // Test sequence
   // ========================================================================
   initial begin
      reset    = 1'b1;
      tx_data  = 8'h00;
      tx_wr    = 1'b0;
      rxd_drv  = 1'b1;
      loopback = 1'b0;
      stop_bit = 1'b1;
      rng      = 32'd38;
      repeat (RESET_CLKS) @(posedge clk);
      reset <= 1'b0;

      u_checker.start_test("reset_idle");        // Quiet line with no writes
      repeat (2 * BIT_CLKS) @(posedge clk);
      u_checker.close_test();

      loopback <= 1'b1;
      u_checker.start_test("tx_frames");
      for (int i = 0; i < N_TX; i++) begin
         rng = xorshift32(rng);
         repeat (rng[10:8]) @(posedge clk);      // Random idle gap
         write_byte(rng[7:0]);
         wait_idle();
      end
      u_checker.close_test();

      u_checker.start_test("busy_ignore");
      for (int i = 0; i < N_IGNORE; i++) begin
         rng = xorshift32(rng);
         write_byte(rng[7:0]);
         repeat (FRAME_CLKS - 1) begin           // Stray writes that all land while busy
            @(posedge clk);
            rng = xorshift32(rng);
            tx_wr   <= rng[0];
            tx_data <= rng[15:8];
         end
         @(posedge clk);
         tx_wr <= 1'b0;
         wait_idle();
      end
      u_checker.close_test();

      u_checker.start_test("loopback_b2b");
      for (int i = 0; i < N_B2B; i++) begin
         rng = xorshift32(rng);
         write_byte(rng[7:0]);                   // Same edge that saw busy fall
         wait_idle();
      end
      u_checker.close_test();

      loopback <= 1'b0;
      u_checker.start_test("frame_error");
      for (int i = 0; i < N_FERR; i++) begin
         rng = xorshift32(rng);
         stop_bit = (rng[9:8] == 2'b00);         // Mostly low stop bits
         u_checker.expect_rx({rng[7:0], ~stop_bit});
         send_frame(rng[7:0], stop_bit);
         drive_line(1'b1, IDLE_CLKS);
      end
      u_checker.close_test();

      u_checker.start_test("glitch_reject");
      for (int i = 0; i < N_GLITCH; i++) begin
         rng = xorshift32(rng);
         drive_line(1'b0, 1 + (rng[10:8] % 7)); // 1 to 7 clocks low
         drive_line(1'b1, IDLE_CLKS);
         u_checker.expect_rx({rng[7:0], 1'b0});
         send_frame(rng[7:0], 1'b1);
         drive_line(1'b1, IDLE_CLKS);
      end
      u_checker.close_test();

      $display("Summary: %0d tests run, %0d failed, %0d errors",
               u_checker.tests_run, u_checker.tests_failed, u_checker.errors);
      if (u_checker.errors == 0) begin
         $display("** PASS **");
      end
      else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
verification/uart_sva.sv
verification/uart_checker.sv
verification/uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module uart_tb -o uart_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/uart_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -Fxq "** PASS **" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1
